/* branch_predictor_top.f */
+incdir+dv
hw/bp_pkg.sv
hw/fetch_pc_unit.sv
hw/resolve_check.sv
hw/pattern_table.sv
hw/global_history.sv
hw/table_chooser.sv
hw/branch_hit_counter.sv
hw/branch_predictor_top.sv
dv/tb_branch_predictor.sv

/* Makefile */
TOP = tb_branch_predictor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f branch_predictor_top.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* dv/bp_model.svh */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// model state
// ~~~~~~~~~~~~~~~~~~~~

prediction_t             m_local_ctr  [TABLE_SIZE];
addr_t                   m_local_tgt  [TABLE_SIZE];
prediction_t             m_global_ctr [TABLE_SIZE];
addr_t                   m_global_tgt [TABLE_SIZE];
logic [HISTORY_BITS-1:0] m_history;
chooser_state_t          m_chooser;
addr_t                   m_pc;
logic [COUNT_BITS-1:0]   m_hits;

// expected values for the cycle in progress.
logic        exp_resolving;
logic        exp_taken;
logic        exp_flush;
addr_t       exp_actual;
addr_t       exp_redirect;
prediction_t exp_prediction;
addr_t       exp_fetch_target;

function automatic int local_index(addr_t addr);
    return int'(addr[INDEX_BITS+1:2]);     // word address bits above the byte offset.
endfunction

function automatic logic predicts_taken(prediction_t p);
    return (p == wt) || (p == st);
endfunction

function automatic prediction_t step_counter(prediction_t p, logic up);
    if (up) begin
        return (p == st) ? st : prediction_t'(p + 2'd1);
    end
    return (p == snt) ? snt : prediction_t'(p - 2'd1);   // both ends saturate.
endfunction

task automatic reset_model();
    for (int i = 0; i < TABLE_SIZE; i++) begin
        m_local_ctr[i]  = wnt;
        m_local_tgt[i]  = '0;
        m_global_ctr[i] = wnt;
        m_global_tgt[i] = '0;
    end
    m_history = '0;
    m_chooser = local_strong;
    m_pc      = RESET_PC;
    m_hits    = '0;
endtask

task automatic predict_outputs();
    int   li;
    int   gi;
    logic guessed;
    li = local_index(m_pc);
    gi = li ^ int'(m_history);
    if (m_chooser == global_weak || m_chooser == global_strong) begin
        exp_prediction   = m_global_ctr[gi];
        exp_fetch_target = m_global_tgt[gi];
    end else begin
        exp_prediction   = m_local_ctr[li];
        exp_fetch_target = m_local_tgt[li];
    end
    exp_resolving = resolve_valid && (resolve_kind != ctrl_none);
    exp_taken     = (resolve_kind == ctrl_branch) ? resolve_br_en : 1'b1;
    exp_actual    = resolve_target;
    if (resolve_kind == ctrl_jalr) begin
        exp_actual[0] = 1'b0;
    end
    guessed      = predicts_taken(resolve_prediction);
    exp_flush    = exp_resolving && ((guessed != exp_taken) ||
                                     (guessed && resolve_pred_target != exp_actual));
    exp_redirect = exp_taken ? exp_actual : resolve_pc + 32'd4;
endtask

// moves the model across one rising edge with this cycle's inputs.
task automatic advance_model();
    int li;
    int gi;
    li = local_index(resolve_pc);
    gi = li ^ int'(m_history);              // hashed with the history before it shifts.
    if (exp_resolving) begin
        m_local_ctr[li]  = step_counter(m_local_ctr[li], exp_taken);
        m_global_ctr[gi] = step_counter(m_global_ctr[gi], exp_taken);
        if (exp_taken) begin
            m_local_tgt[li]  = exp_actual;
            m_global_tgt[gi] = exp_actual;
        end
        if (resolve_kind == ctrl_branch) begin
            m_history = {m_history[HISTORY_BITS-2:0], exp_taken};
        end
        if (!exp_flush && m_hits != '1) begin
            m_hits = m_hits + 1'b1;
        end
    end
    if (exp_flush) begin
        case (m_chooser)
            local_strong: m_chooser = local_weak;
            local_weak:   m_chooser = global_weak;
            global_weak:  m_chooser = local_weak;
            default:      m_chooser = global_weak;
        endcase
    end else if (exp_resolving && m_chooser == local_weak) begin
        m_chooser = local_strong;
    end else if (exp_resolving && m_chooser == global_weak) begin
        m_chooser = global_strong;
    end
    if (!stall) begin
        if (exp_flush) begin
            m_pc = exp_redirect;
        end else if (fetch_opcode == OP_JAL || fetch_opcode == OP_JALR ||
                     (fetch_opcode == OP_BR && predicts_taken(exp_prediction))) begin
            m_pc = exp_fetch_target;
        end else begin
            m_pc = m_pc + 32'd4;
        end
    end
endtask

`endif

/* dv/tb_branch_predictor.sv */
`timescale 1ns/100ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int    INDEX_BITS    = DEFAULT_INDEX_BITS;
    localparam int    HISTORY_BITS  = DEFAULT_HISTORY_BITS;
    localparam int    COUNT_BITS    = 16;
    localparam addr_t RESET_PC      = 32'h0000_0080;
    localparam int    TABLE_SIZE    = 1 << INDEX_BITS;
    localparam int    RANDOM_CYCLES = 3000;
    localparam int    WAIT_LIMIT    = 20;
    localparam addr_t TRAIN_TARGET  = 32'h0000_0400;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  stall;
    opcode_t               fetch_opcode;
    logic                  resolve_valid;
    ctrl_kind_t            resolve_kind;
    addr_t                 resolve_pc;
    addr_t                 resolve_target;
    addr_t                 resolve_pred_target;
    logic                  resolve_br_en;
    prediction_t           resolve_prediction;
    addr_t                 pc;
    prediction_t           fetch_prediction;
    addr_t                 fetch_target;
    logic                  flush;
    logic [COUNT_BITS-1:0] hit_count;

    int seed   = 32'h490b;
    int errors = 0;
    int checks = 0;

    `include "bp_model.svh"

    branch_predictor_top #(
        .INDEX_BITS(INDEX_BITS), .HISTORY_BITS(HISTORY_BITS),
        .COUNT_BITS(COUNT_BITS), .RESET_PC(RESET_PC)
    ) DUT (
        .clk(clk), .rst(rst), .stall(stall), .fetch_opcode(fetch_opcode),
        .resolve_valid(resolve_valid), .resolve_kind(resolve_kind),
        .resolve_pc(resolve_pc), .resolve_target(resolve_target),
        .resolve_pred_target(resolve_pred_target), .resolve_br_en(resolve_br_en),
        .resolve_prediction(resolve_prediction),
        .pc(pc), .fetch_prediction(fetch_prediction), .fetch_target(fetch_target),
        .flush(flush), .hit_count(hit_count)
    );

    always #20 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timed out waiting for %s", what);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // per cycle checks
    // ~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            reset_model();                  // the next edge resets the DUT as well.
        end else begin
            predict_outputs();
            compare_value("pc", pc, m_pc);
            compare_value("fetch_prediction", 32'(fetch_prediction), 32'(exp_prediction));
            compare_value("fetch_target", fetch_target, exp_fetch_target);
            compare_value("flush", 32'(flush), 32'(exp_flush));
            compare_value("hit_count", 32'(hit_count), 32'(m_hits));
            advance_model();
        end
    end

    task automatic drive_random();
        int         r;
        ctrl_kind_t kind;
        addr_t      target;
        r = $random(seed);
        stall <= (r[2:0] == 3'd0);          // about one cycle in eight.
        case (r[5:3])
            3'd0, 3'd1: fetch_opcode <= OP_BR;
            3'd2:       fetch_opcode <= OP_JAL;
            3'd3:       fetch_opcode <= OP_JALR;
            default:    fetch_opcode <= opcode_t'(r[14:8]);
        endcase
        kind = ctrl_kind_t'(r[7:6]);
        resolve_valid      <= r[15];
        resolve_kind       <= kind;
        resolve_br_en      <= r[16];
        resolve_prediction <= prediction_t'(r[18:17]);
        r = $random(seed);
        if (r[1:0] != 2'd0) begin
            resolve_pc <= 32'h0000_0100 + 32'(r[4:2]) * 32'd4;   // small pool so entries repeat.
        end else begin
            resolve_pc <= {r[31:2], 2'b00};
        end
        r = $random(seed);
        target = {r[31:2], 1'b0, (kind == ctrl_jalr) && r[1]};    // only jalr may set bit 0.
        resolve_target <= target;
        r = $random(seed);
        case (r[1:0])
            2'd0:    resolve_pred_target <= target;
            2'd1:    resolve_pred_target <= {target[31:1], 1'b0};
            default: resolve_pred_target <= {r[31:2], 2'b00};
        endcase
    endtask

    initial begin
        logic                  done;
        addr_t                 train_pc;
        prediction_t           want_pred;
        addr_t                 want_target;
        logic [COUNT_BITS-1:0] want_hits;
        rst                 = 1'b1;
        stall               = 1'b0;
        fetch_opcode        = 7'h13;
        resolve_valid       = 1'b0;
        resolve_kind        = ctrl_none;
        resolve_pc          = '0;
        resolve_target      = '0;
        resolve_pred_target = '0;
        resolve_br_en       = 1'b0;
        resolve_prediction  = snt;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("pc", pc, RESET_PC);
        compare_value("flush", 32'(flush), 32'd0);
        compare_value("hit_count", 32'(hit_count), 32'd0);
        compare_value("fetch_prediction", 32'(fetch_prediction), 32'(wnt));

        // train one entry with correctly predicted jumps while pc is held.
        @(posedge clk);
        train_pc = m_pc;
        stall               <= 1'b1;
        fetch_opcode        <= OP_BR;
        resolve_valid       <= 1'b1;
        resolve_kind        <= ctrl_jal;
        resolve_pc          <= train_pc;
        resolve_target      <= TRAIN_TARGET;
        resolve_pred_target <= TRAIN_TARGET;
        resolve_prediction  <= st;
        done = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !done; i++) begin
            @(negedge clk);
            done = (fetch_prediction == st);
        end
        if (!done) begin
            report_timeout("the trained entry to reach strongly taken");
        end
        compare_value("fetch_target", fetch_target, TRAIN_TARGET);

        // taken branches predicted not taken flush twice and fill the history.
        @(posedge clk);
        resolve_kind       <= ctrl_branch;
        resolve_br_en      <= 1'b1;
        resolve_prediction <= snt;
        done = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !done; i++) begin
            @(posedge clk);
            done = (m_chooser == global_weak) || (m_chooser == global_strong);
        end
        if (!done) begin
            report_timeout("the chooser to select the global table");
        end
        want_pred   = m_global_ctr[local_index(train_pc) ^ int'(m_history)];
        want_target = m_global_tgt[local_index(train_pc) ^ int'(m_history)];
        resolve_valid <= 1'b0;
        @(negedge clk);
        compare_value("fetch_prediction", 32'(fetch_prediction), 32'(want_pred));
        compare_value("fetch_target", fetch_target, want_target);

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        resolve_valid <= 1'b0;
        want_hits = m_hits;
        @(negedge clk);
        compare_value("hit_count", 32'(hit_count), 32'(want_hits));
        $display("checks %0d  errors %0d  hit_count %0d", checks, errors, hit_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #1ms;
        $display("simulation ran past its time limit");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* hw/branch_predictor_top.sv */
`timescale 1ns/100ps

module branch_predictor_top #(
    parameter int            INDEX_BITS   = bp_pkg::DEFAULT_INDEX_BITS,
    parameter int            HISTORY_BITS = bp_pkg::DEFAULT_HISTORY_BITS,
    parameter int            COUNT_BITS   = 16,
    parameter bp_pkg::addr_t RESET_PC     = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  bp_pkg::opcode_t       fetch_opcode,
    input  logic                  resolve_valid,
    input  bp_pkg::ctrl_kind_t    resolve_kind,
    input  bp_pkg::addr_t         resolve_pc,
    input  bp_pkg::addr_t         resolve_target,
    input  bp_pkg::addr_t         resolve_pred_target,
    input  logic                  resolve_br_en,
    input  bp_pkg::prediction_t   resolve_prediction,
    output bp_pkg::addr_t         pc,
    output bp_pkg::prediction_t   fetch_prediction,
    output bp_pkg::addr_t         fetch_target,
    output logic                  flush,
    output logic [COUNT_BITS-1:0] hit_count
);
    import bp_pkg::*;

    logic                  resolving;
    logic                  taken;
    addr_t                 actual_target;
    addr_t                 redirect_pc;
    logic                  branch_resolved;
    logic                  use_global;
    prediction_t           local_prediction;
    prediction_t           global_prediction;
    addr_t                 local_target;
    addr_t                 global_target;
    logic [INDEX_BITS-1:0] global_lookup_index;
    logic [INDEX_BITS-1:0] global_update_index;

    assign branch_resolved = resolving && (resolve_kind == ctrl_branch);   // jumps leave history alone.

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch side
    // ~~~~~~~~~~~~~~~~~~~~

    fetch_pc_unit #(.INDEX_BITS(INDEX_BITS), .RESET_PC(RESET_PC)) fetch_unit (
        .clk(clk), .rst(rst), .stall(stall), .fetch_opcode(fetch_opcode),
        .use_global(use_global),
        .local_prediction(local_prediction), .global_prediction(global_prediction),
        .local_target(local_target), .global_target(global_target),
        .flush(flush), .redirect_pc(redirect_pc),
        .pc(pc), .fetch_prediction(fetch_prediction), .fetch_target(fetch_target)
    );

    // local table is indexed straight from the pc bits.
    pattern_table #(.INDEX_BITS(INDEX_BITS)) local_table (
        .clk(clk), .rst(rst),
        .lookup_index(pc[INDEX_BITS+1:2]), .update_index(resolve_pc[INDEX_BITS+1:2]),
        .update(resolving), .taken(taken), .actual_target(actual_target),
        .lookup_prediction(local_prediction), .lookup_target(local_target)
    );

    pattern_table #(.INDEX_BITS(INDEX_BITS)) global_table (
        .clk(clk), .rst(rst),
        .lookup_index(global_lookup_index), .update_index(global_update_index),
        .update(resolving), .taken(taken), .actual_target(actual_target),
        .lookup_prediction(global_prediction), .lookup_target(global_target)
    );

    global_history #(.INDEX_BITS(INDEX_BITS), .HISTORY_BITS(HISTORY_BITS)) history_unit (
        .clk(clk), .rst(rst), .pc(pc), .resolve_pc(resolve_pc),
        .branch_resolved(branch_resolved), .taken(taken),
        .lookup_index(global_lookup_index), .update_index(global_update_index)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // resolve side
    // ~~~~~~~~~~~~~~~~~~~~

    resolve_check resolver (
        .resolve_valid(resolve_valid), .resolve_kind(resolve_kind),
        .resolve_pc(resolve_pc), .resolve_target(resolve_target),
        .resolve_pred_target(resolve_pred_target), .resolve_br_en(resolve_br_en),
        .resolve_prediction(resolve_prediction),
        .resolving(resolving), .taken(taken), .actual_target(actual_target),
        .flush(flush), .redirect_pc(redirect_pc)
    );

    table_chooser chooser (
        .clk(clk), .rst(rst), .resolving(resolving), .flush(flush), .use_global(use_global)
    );

    branch_hit_counter #(.COUNT_BITS(COUNT_BITS)) hit_counter (
        .clk(clk), .rst(rst), .resolving(resolving), .flush(flush), .hit_count(hit_count)
    );

endmodule

/* hw/branch_hit_counter.sv */
`timescale 1ns/100ps

module branch_hit_counter #(
    parameter int COUNT_BITS = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  resolving,
    input  logic                  flush,
    output logic [COUNT_BITS-1:0] hit_count
);

    localparam logic [COUNT_BITS-1:0] COUNT_MAX = '1;

    logic hit;
    logic at_max;

    assign hit    = resolving && !flush;        // resolved with no redirect needed.
    assign at_max = (hit_count == COUNT_MAX);

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_count <= '0;
        end else if (hit && !at_max) begin
            hit_count <= hit_count + 1'b1;      // sticks at all ones once full.
        end
    end

endmodule

/* hw/table_chooser.sv */
`timescale 1ns/100ps

module table_chooser (
    input  logic clk,
    input  logic rst,
    input  logic resolving,
    input  logic flush,
    output logic use_global
);
    import bp_pkg::*;

    chooser_state_t state;
    chooser_state_t state_next;

    always_comb begin
        state_next = state;
        if (flush) begin
            // a miss weakens the current side, and a second miss swaps sides.
            unique case (state)
                local_strong:  state_next = local_weak;
                local_weak:    state_next = global_weak;
                global_weak:   state_next = local_weak;
                global_strong: state_next = global_weak;
                default:       state_next = local_strong;
            endcase
        end else if (resolving) begin
            unique case (state)
                local_weak:  state_next = local_strong;
                global_weak: state_next = global_strong;
                default:     state_next = state;     // strong states stay put.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= local_strong;
        end else begin
            state <= state_next;
        end
    end

    assign use_global = (state == global_weak) || (state == global_strong);

    // the selected side only changes on a misprediction.
    a_side_needs_flush: assert property (
        @(posedge clk) disable iff (rst) !flush |=> $stable(use_global)
    ) else $error("chooser switched tables without a flush");

endmodule

/* hw/global_history.sv */
`timescale 1ns/100ps

module global_history #(
    parameter int INDEX_BITS   = bp_pkg::DEFAULT_INDEX_BITS,
    parameter int HISTORY_BITS = bp_pkg::DEFAULT_HISTORY_BITS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  bp_pkg::addr_t         pc,
    input  bp_pkg::addr_t         resolve_pc,
    input  logic                  branch_resolved,
    input  logic                  taken,
    output logic [INDEX_BITS-1:0] lookup_index,
    output logic [INDEX_BITS-1:0] update_index
);

    logic [HISTORY_BITS-1:0] history;
    logic [INDEX_BITS-1:0]   history_ext;

    if (HISTORY_BITS > INDEX_BITS) begin : g_depth_check
        $error("HISTORY_BITS %0d exceeds INDEX_BITS %0d", HISTORY_BITS, INDEX_BITS);
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // outcome shift register
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
        end else if (branch_resolved) begin
            history <= (history << 1) | HISTORY_BITS'(taken);   // newest outcome in the lsb.
        end
    end

    assign history_ext = INDEX_BITS'(history);   // zero extended to the index width.

    // lookup and update both hash with the current history.
    assign lookup_index = pc[INDEX_BITS+1:2] ^ history_ext;
    assign update_index = resolve_pc[INDEX_BITS+1:2] ^ history_ext;

endmodule

/* hw/pattern_table.sv */
`timescale 1ns/100ps

module pattern_table #(
    parameter int INDEX_BITS = bp_pkg::DEFAULT_INDEX_BITS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INDEX_BITS-1:0] lookup_index,
    input  logic [INDEX_BITS-1:0] update_index,
    input  logic                  update,
    input  logic                  taken,
    input  bp_pkg::addr_t         actual_target,
    output bp_pkg::prediction_t   lookup_prediction,
    output bp_pkg::addr_t         lookup_target
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << INDEX_BITS;

    prediction_t counters [ENTRIES];
    addr_t       targets  [ENTRIES];
    prediction_t current;
    prediction_t stepped;

    // lookup reads the state from before this cycle's update.
    assign lookup_prediction = counters[lookup_index];
    assign lookup_target     = targets[lookup_index];

    // ~~~~~~~~~~~~~~~~~~~~
    // saturating counter step
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        current = counters[update_index];
        unique case (current)
            snt:     stepped = taken ? wnt : snt;
            wnt:     stepped = taken ? wt : snt;
            wt:      stepped = taken ? st : wnt;
            st:      stepped = taken ? st : wt;
            default: stepped = wnt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= wnt;     // start weakly not taken.
                targets[i]  <= '0;
            end
        end else if (update) begin
            counters[update_index] <= stepped;
            if (taken) begin
                targets[update_index] <= actual_target;   // a not taken resolve keeps the old target.
            end
        end
    end

    // the update index is hashed from resolve_pc and history in another block.
    a_update_index_known: assert property (
        @(posedge clk) disable iff (rst) update |-> !$isunknown(update_index)
    ) else $error("pattern table update with unknown index");

endmodule

/* hw/resolve_check.sv */
`timescale 1ns/100ps

module resolve_check (
    input  logic                resolve_valid,
    input  bp_pkg::ctrl_kind_t  resolve_kind,
    input  bp_pkg::addr_t       resolve_pc,
    input  bp_pkg::addr_t       resolve_target,
    input  bp_pkg::addr_t       resolve_pred_target,
    input  logic                resolve_br_en,
    input  bp_pkg::prediction_t resolve_prediction,
    output logic                resolving,
    output logic                taken,
    output bp_pkg::addr_t       actual_target,
    output logic                flush,
    output bp_pkg::addr_t       redirect_pc
);
    import bp_pkg::*;

    logic pred_taken;
    logic dir_wrong;
    logic target_wrong;

    always_comb begin
        resolving = resolve_valid && (resolve_kind != ctrl_none);

        // direction and target that the instruction really takes.
        unique case (resolve_kind)
            ctrl_branch: begin
                taken         = resolve_br_en;
                actual_target = resolve_target;
            end
            ctrl_jal: begin
                taken         = 1'b1;
                actual_target = resolve_target;
            end
            ctrl_jalr: begin
                taken         = 1'b1;
                actual_target = {resolve_target[ADDR_BITS-1:1], 1'b0};   // jalr drops bit 0.
            end
            default: begin
                taken         = 1'b0;
                actual_target = resolve_target;
            end
        endcase

        pred_taken   = (resolve_prediction == wt) || (resolve_prediction == st);
        dir_wrong    = (pred_taken != taken);
        target_wrong = pred_taken && (resolve_pred_target != actual_target);   // only matters if fetch jumped.

        flush = resolving && (dir_wrong || target_wrong);

        if (taken) begin
            redirect_pc = actual_target;
        end else begin
            redirect_pc = resolve_pc + ADDR_BITS'(4);   // fall through past the branch.
        end
    end

endmodule

/* hw/fetch_pc_unit.sv */
`timescale 1ns/100ps

module fetch_pc_unit #(
    parameter int            INDEX_BITS = bp_pkg::DEFAULT_INDEX_BITS,
    parameter bp_pkg::addr_t RESET_PC   = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  bp_pkg::opcode_t     fetch_opcode,
    input  logic                use_global,
    input  bp_pkg::prediction_t local_prediction,
    input  bp_pkg::prediction_t global_prediction,
    input  bp_pkg::addr_t       local_target,
    input  bp_pkg::addr_t       global_target,
    input  logic                flush,
    input  bp_pkg::addr_t       redirect_pc,
    output bp_pkg::addr_t       pc,
    output bp_pkg::prediction_t fetch_prediction,
    output bp_pkg::addr_t       fetch_target
);
    import bp_pkg::*;

    logic  is_jump;
    logic  is_branch;
    logic  predict_taken;
    logic  follow_target;
    addr_t pc_next;

    // the table index is taken from pc bits above the byte offset.
    if (INDEX_BITS + 2 > ADDR_BITS) begin : g_index_check
        $error("INDEX_BITS %0d does not fit in a %0d-bit pc", INDEX_BITS, ADDR_BITS);
    end

    if (RESET_PC[1:0] != 2'b00) begin : g_reset_check
        $error("RESET_PC must be word aligned");
    end

    // entry of whichever table the chooser currently trusts.
    assign fetch_prediction = use_global ? global_prediction : local_prediction;
    assign fetch_target     = use_global ? global_target : local_target;

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch predecode
    // ~~~~~~~~~~~~~~~~~~~~

    assign is_jump       = (fetch_opcode == OP_JAL) || (fetch_opcode == OP_JALR);   // jumps always redirect.
    assign is_branch     = (fetch_opcode == OP_BR);
    assign predict_taken = (fetch_prediction == wt) || (fetch_prediction == st);
    assign follow_target = is_jump || (is_branch && predict_taken);

    // ~~~~~~~~~~~~~~~~~~~~
    // next pc selection
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (flush) begin
            pc_next = redirect_pc;              // resolve side overrides any prediction.
        end else if (follow_target) begin
            pc_next = fetch_target;
        end else begin
            pc_next = pc + ADDR_BITS'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;                      // a stall holds pc even when a flush is pending.
        end
    end

    // targets come from the tables and the resolve side, so alignment is a system property.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc lost word alignment: %h", pc);

endmodule

/* hw/bp_pkg.sv */
package bp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // widths and vectors
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_BITS = 32;   // width of a pc or a branch target.

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [6:0] opcode_t;    // the rv32i opcode field, bits 6 to 0.

    // ~~~~~~~~~~~~~~~~~~~~
    // rv32i control opcodes
    // ~~~~~~~~~~~~~~~~~~~~

    localparam opcode_t OP_BR   = 7'b1100011;   // conditional branch.
    localparam opcode_t OP_JAL  = 7'b1101111;   // jump and link.
    localparam opcode_t OP_JALR = 7'b1100111;   // jump and link register.

    // ~~~~~~~~~~~~~~~~~~~~
    // state encodings
    // ~~~~~~~~~~~~~~~~~~~~

    // 2-bit direction counter. the upper half of the range means taken.
    typedef enum logic [1:0] {
        snt = 2'b00,
        wnt = 2'b01,
        wt  = 2'b10,
        st  = 2'b11
    } prediction_t;

    // kind of the control instruction seen at resolve.
    typedef enum logic [1:0] {
        ctrl_none   = 2'b00,
        ctrl_branch = 2'b01,
        ctrl_jal    = 2'b10,
        ctrl_jalr   = 2'b11
    } ctrl_kind_t;

    // the chooser drifts toward the table that has been mispredicting less.
    typedef enum logic [1:0] {
        local_strong  = 2'b00,
        local_weak    = 2'b01,
        global_weak   = 2'b10,
        global_strong = 2'b11
    } chooser_state_t;

    // defaults for the top level parameters.
    localparam int DEFAULT_INDEX_BITS   = 5;
    localparam int DEFAULT_HISTORY_BITS = 4;

endpackage
